// ==== src/gfx_pkg.sv ====
package gfx_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Data path sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int SHADER_LANES = 4;
	localparam int WORD_BITS    = 32;
	localparam int SHIFT_BITS   = $clog2(WORD_BITS); // Low bits of b used as shift amount

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lane types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [WORD_BITS-1:0]    word;
	typedef logic [SHADER_LANES-1:0] lane_mask; // One flag per lane

	// Signed saturation limits
	localparam word WORD_MAX = {1'b0, {(WORD_BITS-1){1'b1}}};
	localparam word WORD_MIN = {1'b1, {(WORD_BITS-1){1'b0}}};

endpackage

// ==== src/gfx_op_pkg.sv ====
package gfx_op_pkg;

	localparam int OPCODE_BITS   = 3;
	localparam int CFG_DATA_BITS = 8;

	typedef enum logic [OPCODE_BITS-1:0] {
		OP_ADD,
		OP_SUB,
		OP_MIN,
		OP_MAX,
		OP_SHL,
		OP_SHR,
		OP_CLZ,
		OP_MOV
	} fpint_opcode;

	localparam fpint_opcode OPCODE_RESET = OP_MOV;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Configuration port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic {
		CFG_OPCODE,
		CFG_MODE
	} cfg_addr_e;

	// Bit positions inside the mode register
	localparam int MODE_MINMAX_ABS    = 0;
	localparam int MODE_SHIFTR_SIGNED = 1;
	localparam int MODE_ADDSUB_SAT    = 2;

	typedef enum logic {
		CFG_IDLE,
		CFG_ACK
	} cfg_state_e;

endpackage

// ==== src/gfx_op_regs.sv ====
`timescale 1ns/100ps

module gfx_op_regs
import gfx_op_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,

	input  logic                     cfg_req,
	input  cfg_addr_e                cfg_addr,
	input  logic [CFG_DATA_BITS-1:0] cfg_data,
	output logic                     cfg_ack,

	output fpint_opcode              opcode,
	output logic                     minmax_abs,
	output logic                     shiftr_int_signed,
	output logic                     addsub_sat
);

	cfg_state_e state;
	logic       do_write;

	// One write per request, taken on the idle edge that sees req high
	assign do_write = (state == CFG_IDLE) && cfg_req;
	assign cfg_ack = (state == CFG_ACK);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= CFG_IDLE;
		end else begin
			case (state)
				CFG_IDLE:
					if (cfg_req)
						state <= CFG_ACK;
				CFG_ACK:
					if (!cfg_req)
						state <= CFG_IDLE; // Host released req, drop ack
				default:
					state <= CFG_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			opcode            <= OPCODE_RESET;
			minmax_abs        <= 1'b0;
			shiftr_int_signed <= 1'b0;
			addsub_sat        <= 1'b0;
		end else if (do_write) begin
			case (cfg_addr)
				CFG_OPCODE:
					opcode <= fpint_opcode'(cfg_data[OPCODE_BITS-1:0]);
				CFG_MODE: begin
					minmax_abs        <= cfg_data[MODE_MINMAX_ABS];
					shiftr_int_signed <= cfg_data[MODE_SHIFTR_SIGNED];
					addsub_sat        <= cfg_data[MODE_ADDSUB_SAT];
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== src/gfx_lane_alu.sv ====
`timescale 1ns/100ps

module gfx_lane_alu
import gfx_pkg::*, gfx_op_pkg::*;
(
	input  word         a,
	input  word         b,
	input  fpint_opcode opcode,
	input  logic        minmax_abs,
	input  logic        shiftr_int_signed,
	input  logic        addsub_sat,
	output word         q,
	output logic        sat
);

	word                   sum;
	word                   diff;
	word                   mm_a;
	word                   mm_b;
	word                   shr_res;
	word                   clz;
	logic [SHIFT_BITS-1:0] shamt;
	logic                  add_ovf;
	logic                  sub_ovf;
	logic                  a_lt_b;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Add / subtract with signed overflow detect
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign sum = a + b;
	assign diff = a - b;
	assign add_ovf = (a[WORD_BITS-1] == b[WORD_BITS-1]) && (sum[WORD_BITS-1] != a[WORD_BITS-1]);
	assign sub_ovf = (a[WORD_BITS-1] != b[WORD_BITS-1]) && (diff[WORD_BITS-1] != a[WORD_BITS-1]);

	// Abs of the most negative value wraps back to itself
	assign mm_a = (minmax_abs && a[WORD_BITS-1]) ? -a : a;
	assign mm_b = (minmax_abs && b[WORD_BITS-1]) ? -b : b;
	assign a_lt_b = $signed(mm_a) < $signed(mm_b);

	assign shamt = b[SHIFT_BITS-1:0];
	assign shr_res = shiftr_int_signed ? word'($signed(a) >>> shamt) : a >> shamt;

	always_comb begin
		clz = word'(WORD_BITS);
		for (int i = 0; i < WORD_BITS; i++) begin
			if (a[i])
				clz = word'(WORD_BITS - 1 - i); // Highest set bit wins
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Result select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		q = a;
		sat = 1'b0;
		case (opcode)
			OP_ADD: begin
				q = sum;
				if (addsub_sat && add_ovf) begin
					q = a[WORD_BITS-1] ? WORD_MIN : WORD_MAX;
					sat = 1'b1;
				end
			end
			OP_SUB: begin
				q = diff;
				if (addsub_sat && sub_ovf) begin
					q = a[WORD_BITS-1] ? WORD_MIN : WORD_MAX;
					sat = 1'b1;
				end
			end
			OP_MIN: q = a_lt_b ? mm_a : mm_b;
			OP_MAX: q = a_lt_b ? mm_b : mm_a;
			OP_SHL: q = a << shamt;
			OP_SHR: q = shr_res;
			OP_CLZ: q = clz;
			OP_MOV: q = a;
			default: q = a;
		endcase
	end

endmodule

// ==== src/gfx_shader_fpint.sv ====
`timescale 1ns/100ps

module gfx_shader_fpint
import gfx_pkg::*, gfx_op_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	input  logic        in_valid,
	input  word         a[SHADER_LANES],
	input  word         b[SHADER_LANES],

	input  fpint_opcode opcode,
	input  logic        minmax_abs,
	input  logic        shiftr_int_signed,
	input  logic        addsub_sat,

	output logic        out_valid,
	output word         q[SHADER_LANES],
	output lane_mask    sat
);

	logic        s1_valid;
	word         s1_a[SHADER_LANES];
	word         s1_b[SHADER_LANES];
	fpint_opcode s1_opcode;
	logic        s1_minmax_abs;
	logic        s1_shiftr_int_signed;
	logic        s1_addsub_sat;

	word         lane_q[SHADER_LANES];
	lane_mask    lane_sat;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 1, operands travel with their own configuration
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_a                 <= a;
			s1_b                 <= b;
			s1_opcode            <= opcode;
			s1_minmax_abs        <= minmax_abs;
			s1_shiftr_int_signed <= shiftr_int_signed;
			s1_addsub_sat        <= addsub_sat;
		end
	end

	for (genvar i = 0; i < SHADER_LANES; i++) begin : g_lane
		gfx_lane_alu u_alu
		(
			.a(s1_a[i]),
			.b(s1_b[i]),
			.opcode(s1_opcode),
			.minmax_abs(s1_minmax_abs),
			.shiftr_int_signed(s1_shiftr_int_signed),
			.addsub_sat(s1_addsub_sat),
			.q(lane_q[i]),
			.sat(lane_sat[i])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 2, lane results
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
			sat       <= '0;
		end else begin
			s1_valid  <= in_valid;
			out_valid <= s1_valid;
			if (s1_valid)
				sat <= lane_sat;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid)
			q <= lane_q;
	end

endmodule

// ==== src/gfx_top.sv ====
`timescale 1ns/100ps

module gfx_top
import gfx_pkg::*, gfx_op_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,

	input  word                      a[SHADER_LANES],
	input  word                      b[SHADER_LANES],
	input  logic                     in_valid,
	output logic                     out_valid,
	output word                      q[SHADER_LANES],
	output lane_mask                 sat,

	input  logic                     cfg_req,
	input  cfg_addr_e                cfg_addr,
	input  logic [CFG_DATA_BITS-1:0] cfg_data,
	output logic                     cfg_ack
);

	fpint_opcode opcode;
	logic        minmax_abs;
	logic        shiftr_int_signed;
	logic        addsub_sat;

	gfx_op_regs u_regs
	(
		.clk,
		.rst_n,
		.cfg_req,
		.cfg_addr,
		.cfg_data,
		.cfg_ack,
		.opcode,
		.minmax_abs,
		.shiftr_int_signed,
		.addsub_sat
	);

	gfx_shader_fpint u_fpint
	(
		.clk,
		.rst_n,
		.in_valid,
		.a,
		.b,
		.opcode,
		.minmax_abs,
		.shiftr_int_signed,
		.addsub_sat,
		.out_valid,
		.q,
		.sat
	);

endmodule

// ==== test/gfx_top_asserts.sv ====
`timescale 1ns/100ps

module gfx_top_asserts (
	input logic clk,
	input logic rst_n,
	input logic cfg_req,
	input logic cfg_ack,
	input logic in_valid,
	input logic out_valid
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Four-phase configuration handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cfg_ack) |-> cfg_req)
		else $error("cfg_ack rose while cfg_req was low");

	ack_held: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_ack && cfg_req |=> cfg_ack)
		else $error("cfg_ack dropped while cfg_req was still high");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pipeline timing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid, 2))
		else $error("out_valid does not follow in_valid by two cycles");

	valid_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

endmodule

// Each binding ties off the half that the target does not own
bind gfx_op_regs gfx_top_asserts u_regs_asserts (
	.clk, .rst_n, .cfg_req, .cfg_ack, .in_valid(1'b0), .out_valid(1'b0)
);

bind gfx_shader_fpint gfx_top_asserts u_fpint_asserts (
	.clk, .rst_n, .cfg_req(1'b0), .cfg_ack(1'b0), .in_valid, .out_valid
);

// ==== test/gfx_top_tb.sv ====
`timescale 1ns/100ps

module gfx_top_tb
import gfx_pkg::*, gfx_op_pkg::*;
();

	localparam int ACK_LIMIT   = 20;
	localparam int DRAIN_LIMIT = 50;

	logic                     clk;
	logic                     rst_n;
	word                      a[SHADER_LANES];
	word                      b[SHADER_LANES];
	logic                     in_valid;
	logic                     out_valid;
	word                      q[SHADER_LANES];
	lane_mask                 sat;
	logic                     cfg_req;
	cfg_addr_e                cfg_addr;
	logic [CFG_DATA_BITS-1:0] cfg_data;
	logic                     cfg_ack;

	integer      seed = 49;
	int          cyc = 0;
	fpint_opcode m_opcode; // Reference copy of the configuration
	logic        m_abs;
	logic        m_shr_signed;
	logic        m_sat;
	word         exp_q[$];
	lane_mask    exp_sat[$];
	int          exp_tag[$];

	gfx_top u_dut (
		.clk, .rst_n, .a, .b, .in_valid, .out_valid, .q, .sat,
		.cfg_req, .cfg_addr, .cfg_data, .cfg_ack
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Error reporting and compares
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic report_fail(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input word exp, input word act, input int lane);
		if (act !== exp) begin
			$display("ERR q[%0d] expected %h actual %h", lane, exp, act);
			report_fail("lane result mismatch");
		end
	endtask

	task automatic check_mask(input lane_mask exp, input lane_mask act);
		if (act !== exp) begin
			$display("ERR sat expected %h actual %h", exp, act);
			report_fail("saturation mask mismatch");
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic word lane_model(input word x, input word y, output logic s);
		longint sx;
		longint sy;
		longint wide;
		word    r;
		word    ax;
		word    ay;
		int     n;
		s = 1'b0;
		r = x;
		sx = {{32{x[31]}}, x};
		sy = {{32{y[31]}}, y};
		n = int'(y[SHIFT_BITS-1:0]);
		ax = (m_abs && x[31]) ? ~x + 1 : x; // 0x80000000 maps to itself
		ay = (m_abs && y[31]) ? ~y + 1 : y;
		case (m_opcode)
			OP_ADD, OP_SUB: begin
				wide = (m_opcode == OP_ADD) ? sx + sy : sx - sy;
				r = wide[31:0];
				if (m_sat && wide > 64'sh0000_0000_7FFF_FFFF) begin
					r = 32'h7FFF_FFFF;
					s = 1'b1;
				end else if (m_sat && wide < 64'shFFFF_FFFF_8000_0000) begin
					r = 32'h8000_0000;
					s = 1'b1;
				end
			end
			OP_MIN: r = ($signed(ax) < $signed(ay)) ? ax : ay;
			OP_MAX: r = ($signed(ax) > $signed(ay)) ? ax : ay;
			OP_SHL: r = x << n;
			OP_SHR: begin
				r = x >> n;
				if (m_shr_signed && x[31])
					r = r | ~(32'hFFFF_FFFF >> n); // Refill with sign bits
			end
			OP_CLZ: begin
				n = 0;
				while (n < 32 && !x[31-n])
					n++;
				r = n;
			end
			default: r = x;
		endcase
		return r;
	endfunction

	// Kind 1 biases toward large magnitudes, kind 2 mixes in corner values
	function automatic word pick_operand(input int kind);
		word r;
		r = $random(seed);
		if (kind == 1) begin
			r = r[31] ? {4'b1000, r[27:0]} : {4'b0111, r[27:0]};
		end else if (kind == 2) begin
			case (r[2:0])
				3'd0: r = 32'h0000_0000;
				3'd1: r = 32'h8000_0000;
				3'd2: r = 32'h7FFF_FFFF;
				3'd3: r = 32'hFFFF_FFFF;
				3'd4: r = r >> r[8:4];
				default: ;
			endcase
		end
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Drivers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic cfg_write(input cfg_addr_e addr, input logic [CFG_DATA_BITS-1:0] data,
			input logic overlap = 1'b0);
		int t;
		@(posedge clk);
		cfg_req <= 1'b1;
		cfg_addr <= addr;
		cfg_data <= data;
		if (overlap) begin
			drive_item(2); // Accepted on the edge that writes the register
			@(posedge clk);
		end
		in_valid <= 1'b0;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!cfg_ack && t < ACK_LIMIT);
		if (!cfg_ack)
			report_fail("cfg_ack did not rise after cfg_req");
		@(posedge clk);
		cfg_req <= 1'b0;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (cfg_ack && t < ACK_LIMIT);
		if (cfg_ack)
			report_fail("cfg_ack stayed high after cfg_req fell");
	endtask

	task automatic set_opcode(input fpint_opcode op, input logic overlap = 1'b0);
		cfg_write(CFG_OPCODE, CFG_DATA_BITS'(op), overlap);
		m_opcode = op;
	endtask

	task automatic set_mode(input logic abs_on, input logic shr_signed, input logic sat_on);
		logic [CFG_DATA_BITS-1:0] d;
		d = '0;
		d[MODE_MINMAX_ABS] = abs_on;
		d[MODE_SHIFTR_SIGNED] = shr_signed;
		d[MODE_ADDSUB_SAT] = sat_on;
		cfg_write(CFG_MODE, d);
		m_abs = abs_on;
		m_shr_signed = shr_signed;
		m_sat = sat_on;
	endtask

	task automatic drive_item(input int kind);
		word      va;
		word      vb;
		logic     s;
		lane_mask m;
		for (int i = 0; i < SHADER_LANES; i++) begin
			va = pick_operand(kind);
			vb = pick_operand(kind);
			a[i] <= va;
			b[i] <= vb;
			exp_q.push_back(lane_model(va, vb, s));
			m[i] = s;
		end
		in_valid <= 1'b1;
		exp_sat.push_back(m);
		exp_tag.push_back(cyc);
	endtask

	task automatic send_item(input int kind);
		@(posedge clk);
		drive_item(kind);
	endtask

	task automatic run_burst(input int count, input int kind);
		int gap;
		for (int i = 0; i < count; i++) begin
			send_item(kind);
			gap = $unsigned($random(seed)) % 4;
			for (int g = 0; g < gap; g++) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// Monitor: driven at one edge, accepted at the next, visible two edges later
	always @(negedge clk) begin
		cyc <= cyc + 1;
		if (rst_n && out_valid) begin
			if (exp_tag.size() == 0) begin
				report_fail("out_valid without an accepted item");
			end else begin
				if (cyc != exp_tag[0] + 2)
					report_fail("result did not arrive two cycles after acceptance");
				void'(exp_tag.pop_front());
				for (int i = 0; i < SHADER_LANES; i++)
					check_word(exp_q.pop_front(), q[i], i);
				check_mask(exp_sat.pop_front(), sat);
			end
		end
	end

	initial begin
		int t;
		rst_n <= 1'b0;
		in_valid <= 1'b0;
		cfg_req <= 1'b0;
		cfg_addr <= CFG_OPCODE;
		cfg_data <= '0;
		for (int i = 0; i < SHADER_LANES; i++) begin
			a[i] <= '0;
			b[i] <= '0;
		end
		m_opcode = OPCODE_RESET;
		m_abs = 1'b0;
		m_shr_signed = 1'b0;
		m_sat = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);

		run_burst(20, 0); // Reset opcode passes a through

		for (int md = 0; md < 8; md++) begin
			set_mode(md[0], md[1], md[2]);
			for (int op = 0; op <= int'(OP_MOV); op++) begin
				set_opcode(fpint_opcode'(op));
				run_burst(8, (op % 2 == 0) ? 2 : 0);
			end
		end

		// Large operands, saturating then wrapping
		for (int sm = 1; sm >= 0; sm--) begin
			set_mode(1'b0, 1'b0, sm[0]);
			set_opcode(OP_ADD);
			run_burst(24, 1);
			set_opcode(OP_SUB);
			run_burst(24, 1);
		end

		// Opcode change with two items in flight
		set_opcode(OP_ADD);
		send_item(2);
		send_item(2);
		set_opcode(OP_SUB, 1'b1);
		run_burst(6, 2);

		t = 0;
		while (exp_tag.size() != 0 && t < DRAIN_LIMIT) begin
			@(negedge clk);
			t++;
		end
		if (exp_tag.size() != 0) begin
			report_fail("timed out waiting for outstanding results");
		end else begin
			repeat (5) @(posedge clk);
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// ==== project.f ====
src/gfx_pkg.sv
src/gfx_op_pkg.sv
src/gfx_op_regs.sv
src/gfx_lane_alu.sv
src/gfx_shader_fpint.sv
src/gfx_top.sv
test/gfx_top_asserts.sv
test/gfx_top_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= gfx_top_tb
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
